// ==== design/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    localparam int FFT_LEN      = 128;
    localparam int FFT_LOG      = 7;
    localparam int TILE_IN      = 8;
    localparam int TILE_OUT     = 6;
    localparam int KERNEL       = 3;
    localparam int FRAC_BITS    = 21;
    localparam int PIX_PER_WORD = 4;
    localparam int WRITE_BASE   = 18;   // Offset (2,2) inside the 8-wide tile

    typedef logic signed [7:0]  pixel_t;
    typedef logic [31:0]        word_t;
    typedef logic [15:0]        addr_t;
    typedef logic signed [64:0] fix_t;
    typedef logic [FFT_LOG-1:0] idx_t;

    typedef struct packed {
        fix_t re;
        fix_t im;
    } cplx_t;

    typedef struct packed {
        logic [3:0] row;
        logic [3:0] col;
    } coord_t;

    typedef struct packed {
        logic [15:0] row;
        logic [15:0] col;
    } org_t;

    typedef enum logic [2:0] {OP_CLEAR, OP_BITREV, OP_FWD, OP_MUL, OP_INV} fft_op_e;

endpackage

`default_nettype wire

// ==== design/twiddle_rom.sv ====
`default_nettype none

// Indexed by half span, so 1 stands for a butterfly span of 2 and 64 for 128
module twiddle_rom import conv_pkg::*; (
    input  idx_t  span_i,
    input  logic  inverse_i,
    output cplx_t twiddle_o
);

    localparam fix_t ONE = fix_t'(1) <<< FRAC_BITS;

    fix_t cos_v;
    fix_t sin_v;

    always_comb begin
        cos_v = '0;
        sin_v = '0;
        case (span_i)
            idx_t'(1):  cos_v = -ONE;
            idx_t'(2):  sin_v = ONE;
            idx_t'(4):  begin cos_v = fix_t'(1482910); sin_v = fix_t'(1482910); end
            idx_t'(8):  begin cos_v = fix_t'(1937515); sin_v = fix_t'(802545);  end
            idx_t'(16): begin cos_v = fix_t'(2056855); sin_v = fix_t'(409134);  end
            idx_t'(32): begin cos_v = fix_t'(2087053); sin_v = fix_t'(205556);  end
            idx_t'(64): begin cos_v = fix_t'(2094625); sin_v = fix_t'(102902);  end
            default: ;
        endcase
        twiddle_o.re = cos_v;
        twiddle_o.im = inverse_i ? sin_v : -sin_v;  // exp(-j) forward, exp(+j) inverse
    end

endmodule

`default_nettype wire

// ==== design/tile_fft.sv ====
`default_nettype none

module tile_fft import conv_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    op_start_i,
    input  fft_op_e op_i,
    input  logic    sel_b_i,
    output logic    op_done_o,
    input  logic    load_en_i,
    input  idx_t    load_idx_i,
    input  word_t   load_word_i,
    input  logic    load_b_i,
    input  idx_t    rd_idx_i,
    output cplx_t   rd_data_o
);

    localparam idx_t LAST = idx_t'(FFT_LEN - 1);
    localparam fix_t ONE  = fix_t'(1) <<< FRAC_BITS;

    typedef enum logic [2:0] {
        F_IDLE, F_CLEAR, F_BITREV, F_STAGE, F_GROUP, F_BFLY, F_MUL, F_SCALE
    } fstate_e;

    fstate_e          state;
    logic             done_q;
    logic             sel_q;
    logic             inv_q;
    idx_t             cnt;
    idx_t             half;      // Half span of the current stage
    logic [FFT_LOG:0] grp;       // Group base, reaches FFT_LEN
    idx_t             k;
    cplx_t            w;
    cplx_t            wn;
    cplx_t            tw;
    cplx_t            prod;
    cplx_t            bf_lo;
    cplx_t            bf_hi;
    cplx_t            w_next;
    idx_t             rev_idx;
    idx_t             hi_idx;

    cplx_t mem [2][FFT_LEN];     // [0] is A, [1] is B

    function automatic fix_t fmul(fix_t a, fix_t b);
        logic signed [2*$bits(fix_t)-1:0] p;
        p = a * b;
        return fix_t'(p >>> FRAC_BITS);
    endfunction

    function automatic cplx_t cmul(cplx_t x, cplx_t y);
        cplx_t r;
        r.re = fmul(x.re, y.re) - fmul(x.im, y.im);
        r.im = fmul(x.re, y.im) + fmul(x.im, y.re);
        return r;
    endfunction

    twiddle_rom u_twiddle (
        .span_i    (half),
        .inverse_i (inv_q),
        .twiddle_o (tw)
    );

    assign rev_idx   = {<<{cnt}};
    assign hi_idx    = k + half;
    assign rd_data_o = mem[0][rd_idx_i];
    assign op_done_o = done_q;

    always_comb begin
        prod     = cmul(mem[sel_q][hi_idx], w);
        bf_lo.re = mem[sel_q][k].re + prod.re;
        bf_lo.im = mem[sel_q][k].im + prod.im;
        bf_hi.re = mem[sel_q][k].re - prod.re;
        bf_hi.im = mem[sel_q][k].im - prod.im;
        w_next   = cmul(w, wn);  // Twiddle recurrence along the group
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state  <= F_IDLE;
            done_q <= 1'b0;
            sel_q  <= 1'b0;
            inv_q  <= 1'b0;
            cnt    <= '0;
            half   <= idx_t'(1);
            grp    <= '0;
            k      <= '0;
        end else begin
            done_q <= 1'b0;
            case (state)
                F_IDLE: if (op_start_i) begin
                    sel_q <= sel_b_i;
                    inv_q <= (op_i == OP_INV);
                    cnt   <= '0;
                    half  <= idx_t'(1);
                    case (op_i)
                        OP_CLEAR:  state <= F_CLEAR;
                        OP_BITREV: state <= F_BITREV;
                        OP_MUL:    state <= F_MUL;
                        default:   state <= F_STAGE;
                    endcase
                end
                F_STAGE: begin
                    grp   <= '0;
                    state <= F_GROUP;
                end
                F_GROUP: begin
                    k     <= idx_t'(grp);
                    state <= F_BFLY;
                end
                F_BFLY: begin
                    k <= k + 1'b1;
                    if (int'(k) + 1 == int'(grp) + int'(half)) begin
                        if (int'(grp) + 2 * int'(half) >= FFT_LEN) begin
                            if (int'(half) == FFT_LEN / 2) begin
                                state  <= inv_q ? F_SCALE : F_IDLE;
                                done_q <= !inv_q;
                            end else begin
                                half  <= half << 1;
                                state <= F_STAGE;
                            end
                        end else begin
                            grp   <= grp + 2 * half;
                            state <= F_GROUP;
                        end
                    end
                end
                default: begin  // Linear sweeps over all points
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST) begin
                        state  <= F_IDLE;
                        done_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_en_i) begin
            for (int n = 0; n < PIX_PER_WORD; n++) begin
                mem[load_b_i][load_idx_i + n].re <=
                    fix_t'(pixel_t'(load_word_i[8*n +: 8])) <<< FRAC_BITS;
                mem[load_b_i][load_idx_i + n].im <= '0;
            end
        end else begin
            case (state)
                F_CLEAR: begin
                    mem[0][cnt] <= '0;
                    mem[1][cnt] <= '0;
                end
                F_BITREV: if (cnt < rev_idx) begin
                    mem[sel_q][cnt]     <= mem[sel_q][rev_idx];
                    mem[sel_q][rev_idx] <= mem[sel_q][cnt];
                end
                F_STAGE: wn <= tw;
                F_GROUP: w <= '{re: ONE, im: '0};
                F_BFLY: begin
                    mem[sel_q][k]      <= bf_lo;
                    mem[sel_q][hi_idx] <= bf_hi;
                    w                  <= w_next;
                end
                F_MUL: mem[0][cnt] <= cmul(mem[0][cnt], mem[1][cnt]);
                F_SCALE: begin  // Divide by FFT_LEN
                    mem[sel_q][cnt].re <= mem[sel_q][cnt].re >>> FFT_LOG;
                    mem[sel_q][cnt].im <= mem[sel_q][cnt].im >>> FFT_LOG;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/tile_engine.sv ====
`default_nettype none

module tile_engine import conv_pkg::*; (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               tile_start_i,
    output logic               tile_done_o,
    input  word_t              input_rdata_i,
    input  word_t              weight_rdata_i,
    output coord_t             in_coord_o,
    output coord_t             wt_coord_o,
    output coord_t             out_coord_o,
    output logic               output_wen_o,
    output logic signed [31:0] output_wdata_o
);

    localparam int LOAD_IMG  = 2 * TILE_IN;              // Two words per tile row
    localparam int LOAD_LAST = LOAD_IMG + KERNEL - 1;    // Then one word per kernel row

    typedef enum logic [3:0] {
        ST_IDLE, ST_CLEAR, ST_LOAD, ST_REV_A, ST_REV_B, ST_FWD_A, ST_FWD_B,
        ST_MUL, ST_IREV_A, ST_INV_A, ST_WRITE
    } estate_e;

    estate_e     state;
    logic        go_q;
    logic        done_q;
    logic [4:0]  cnt;
    logic [2:0]  wr_row;
    logic [2:0]  wr_col;
    logic [95:0] kern_q;     // Three raw weight words
    fft_op_e     op;
    logic        sel_b;
    logic        op_done;
    logic        load_b;
    idx_t        load_idx;
    word_t       load_word;
    int          kbase;
    cplx_t       rd_data;
    fix_t        rounded;

    always_comb begin
        op    = OP_CLEAR;
        sel_b = 1'b0;
        case (state)
            ST_REV_A, ST_IREV_A: op = OP_BITREV;
            ST_REV_B:            begin op = OP_BITREV; sel_b = 1'b1; end
            ST_FWD_A:            op = OP_FWD;
            ST_FWD_B:            begin op = OP_FWD; sel_b = 1'b1; end
            ST_MUL:              op = OP_MUL;
            ST_INV_A:            op = OP_INV;
            default: ;
        endcase
    end

    // Image words first, then the flipped kernel rows into B
    always_comb begin
        kbase = 0;
        if (cnt < LOAD_IMG) begin
            load_b    = 1'b0;
            load_word = input_rdata_i;
            load_idx  = idx_t'(cnt * PIX_PER_WORD);
        end else begin
            kbase     = (KERNEL - 1 - int'(cnt[1:0])) * KERNEL;
            load_b    = 1'b1;
            load_word = {8'h00, kern_q[8*kbase +: 8], kern_q[8*(kbase+1) +: 8],
                         kern_q[8*(kbase+2) +: 8]};
            load_idx  = idx_t'(cnt[1:0] * TILE_IN);
        end
    end

    assign in_coord_o  = '{row: 4'(cnt >> 1), col: 4'(cnt[0] * PIX_PER_WORD)};
    assign wt_coord_o  = '{row: cnt[3:0], col: cnt[3:0]};  // Word n starts at flat 4n
    assign out_coord_o = '{row: {1'b0, wr_row}, col: {1'b0, wr_col}};

    assign rounded        = rd_data.re + (fix_t'(1) <<< (FRAC_BITS - 1));
    assign output_wen_o   = (state == ST_WRITE);
    assign output_wdata_o = 32'(rounded >>> FRAC_BITS);
    assign tile_done_o    = done_q;

    always_ff @(posedge clk_i) begin
        if (state == ST_LOAD && cnt < KERNEL)
            kern_q[32*cnt +: 32] <= weight_rdata_i;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state  <= ST_IDLE;
            go_q   <= 1'b0;
            done_q <= 1'b0;
            cnt    <= '0;
            wr_row <= '0;
            wr_col <= '0;
        end else begin
            go_q   <= 1'b0;
            done_q <= 1'b0;
            case (state)
                ST_IDLE: if (tile_start_i) begin
                    state <= ST_CLEAR;
                    go_q  <= 1'b1;
                end
                ST_LOAD: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 5'(LOAD_LAST)) begin
                        state <= ST_REV_A;
                        go_q  <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    wr_col <= (wr_col == 3'(TILE_OUT - 1)) ? '0 : wr_col + 1'b1;
                    if (wr_col == 3'(TILE_OUT - 1))
                        wr_row <= wr_row + 1'b1;
                    if (wr_row == 3'(TILE_OUT - 1) && wr_col == 3'(TILE_OUT - 1)) begin
                        state  <= ST_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: if (op_done) begin
                    state  <= state.next();
                    cnt    <= '0;
                    wr_row <= '0;
                    wr_col <= '0;
                    go_q   <= (state != ST_CLEAR) && (state != ST_INV_A);
                end
            endcase
        end
    end

    tile_fft u_fft (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .op_start_i  (go_q),
        .op_i        (op),
        .sel_b_i     (sel_b),
        .op_done_o   (op_done),
        .load_en_i   (state == ST_LOAD),
        .load_idx_i  (load_idx),
        .load_word_i (load_word),
        .load_b_i    (load_b),
        .rd_idx_i    (idx_t'(WRITE_BASE + TILE_IN * wr_row + wr_col)),
        .rd_data_o   (rd_data)
    );

endmodule

`default_nettype wire

// ==== design/tile_scheduler.sv ====
`default_nettype none

module tile_scheduler import conv_pkg::*; #(
    parameter int IMG_H = 64,
    parameter int IMG_W = 64
) (
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   valid_i,
    output logic   ready_o,
    output logic   tile_start_o,
    input  logic   tile_done_i,
    input  coord_t in_coord_i,
    input  coord_t wt_coord_i,
    input  coord_t out_coord_i,
    output addr_t  input_addr_o,
    output addr_t  weight_addr_o,
    output addr_t  output_addr_o
);

    localparam int OUT_W = IMG_W - (KERNEL - 1);

    typedef enum logic [1:0] {S_IDLE, S_LAUNCH, S_WAIT, S_FINISH} run_e;
    typedef enum logic [1:0] {PH_INTERIOR, PH_BOTTOM, PH_RIGHT, PH_CORNER} phase_e;

    run_e   state;
    phase_e phase;
    org_t   org_q;

    assign ready_o      = (state == S_FINISH);
    assign tile_start_o = (state == S_LAUNCH);

    assign input_addr_o  = addr_t'((org_q.row + in_coord_i.row) * IMG_W
                                   + org_q.col + in_coord_i.col);
    assign weight_addr_o = addr_t'(wt_coord_i.row * KERNEL + wt_coord_i.col);
    assign output_addr_o = addr_t'((org_q.row + out_coord_i.row) * OUT_W
                                   + org_q.col + out_coord_i.col);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= S_IDLE;
            phase <= PH_INTERIOR;
            org_q <= '0;
        end else begin
            case (state)
                S_IDLE: if (valid_i) begin
                    state <= S_LAUNCH;
                    phase <= PH_INTERIOR;
                    org_q <= '0;
                end
                S_LAUNCH: state <= S_WAIT;
                S_WAIT: if (tile_done_i) begin
                    state <= (phase == PH_CORNER) ? S_FINISH : S_LAUNCH;
                    case (phase)
                        PH_INTERIOR:  // Row-major while a whole tile fits
                            if (org_q.col + TILE_OUT + TILE_IN <= IMG_W) begin
                                org_q.col <= org_q.col + 16'(TILE_OUT);
                            end else if (org_q.row + TILE_OUT + TILE_IN <= IMG_H) begin
                                org_q.row <= org_q.row + 16'(TILE_OUT);
                                org_q.col <= '0;
                            end else begin
                                phase <= PH_BOTTOM;
                                org_q <= '{row: 16'(IMG_H - TILE_IN), col: '0};
                            end
                        PH_BOTTOM:
                            if (org_q.col + TILE_OUT + TILE_IN <= IMG_W) begin
                                org_q.col <= org_q.col + 16'(TILE_OUT);
                            end else begin
                                phase <= PH_RIGHT;
                                org_q <= '{row: '0, col: 16'(IMG_W - TILE_IN)};
                            end
                        PH_RIGHT:
                            if (org_q.row + TILE_OUT + TILE_IN <= IMG_H) begin
                                org_q.row <= org_q.row + 16'(TILE_OUT);
                            end else begin
                                phase <= PH_CORNER;
                                org_q <= '{row: 16'(IMG_H - TILE_IN),
                                           col: 16'(IMG_W - TILE_IN)};
                            end
                        default: ;
                    endcase
                end
                default: ;  // Holds until reset
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/conv_top.sv ====
`default_nettype none

module conv_top import conv_pkg::*; #(
    parameter int IMG_H = 64,
    parameter int IMG_W = 64
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               valid_i,
    output logic               ready_o,
    output addr_t              input_addr_o,
    input  word_t              input_rdata_i,
    output addr_t              weight_addr_o,
    input  word_t              weight_rdata_i,
    output logic               output_wen_o,
    output addr_t              output_addr_o,
    output logic signed [31:0] output_wdata_o
);

    logic   tile_start;
    logic   tile_done;
    coord_t in_coord;
    coord_t wt_coord;
    coord_t out_coord;

    tile_scheduler #(
        .IMG_H (IMG_H),
        .IMG_W (IMG_W)
    ) u_sched (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .valid_i       (valid_i),
        .ready_o       (ready_o),
        .tile_start_o  (tile_start),
        .tile_done_i   (tile_done),
        .in_coord_i    (in_coord),
        .wt_coord_i    (wt_coord),
        .out_coord_i   (out_coord),
        .input_addr_o  (input_addr_o),
        .weight_addr_o (weight_addr_o),
        .output_addr_o (output_addr_o)
    );

    tile_engine u_engine (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .tile_start_i   (tile_start),
        .tile_done_o    (tile_done),
        .input_rdata_i  (input_rdata_i),
        .weight_rdata_i (weight_rdata_i),
        .in_coord_o     (in_coord),
        .wt_coord_o     (wt_coord),
        .out_coord_o    (out_coord),
        .output_wen_o   (output_wen_o),
        .output_wdata_o (output_wdata_o)
    );

endmodule

`default_nettype wire

// ==== dv/conv_chk.sv ====
`default_nettype none

module conv_chk import conv_pkg::*; #(
    parameter int IMG_H = 64,
    parameter int IMG_W = 64
) (
    input logic  clk_i,
    input logic  reset_i,
    input logic  ready_o,
    input logic  output_wen_o,
    input addr_t output_addr_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int OUT_COUNT = (IMG_H - KERNEL + 1) * (IMG_W - KERNEL + 1);

    no_write_when_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        !(output_wen_o && ready_o))
        else $error("output_wen_o high while ready_o is high");

    // Only a reset may take ready_o down
    ready_holds: assert property (@(posedge clk_i)
        ready_o && !reset_i |=> ready_o || reset_i)
        else $error("ready_o fell without reset");

    write_addr_range: assert property (@(posedge clk_i) disable iff (reset_i)
        output_wen_o |-> int'(output_addr_o) < OUT_COUNT)
        else $error("output_addr_o beyond the output memory");

endmodule

bind conv_top conv_chk #(
    .IMG_H (IMG_H),
    .IMG_W (IMG_W)
) u_conv_chk (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .ready_o       (ready_o),
    .output_wen_o  (output_wen_o),
    .output_addr_o (output_addr_o)
);

`default_nettype wire

// ==== dv/tb_conv.sv ====
`default_nettype none

module tb_conv import conv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMG_H     = 16;
    localparam int IMG_W     = 16;
    localparam int OUT_H     = IMG_H - KERNEL + 1;
    localparam int OUT_W     = IMG_W - KERNEL + 1;
    localparam int N_OUT     = OUT_H * OUT_W;
    localparam int PERIOD    = 40;
    localparam int DRIVE_DLY = 2;
    localparam int RUNS      = 2;
    localparam int TILES     = 9;        // 4 interior, 2 bottom, 2 right, 1 corner
    localparam int TILE_MAX  = 6000;     // Generous bound on one tile's cycles
    localparam int TIMEOUT_CYCLES = RUNS * TILES * TILE_MAX + 12000;
    localparam logic [31:0] SEED = 32'h1a15bb34;

    logic               clk;
    logic               reset;
    logic               valid;
    logic               ready;
    addr_t              input_addr;
    word_t              input_rdata;
    addr_t              weight_addr;
    word_t              weight_rdata;
    logic               output_wen;
    addr_t              output_addr;
    logic signed [31:0] output_wdata;

    pixel_t             img [IMG_H * IMG_W];
    pixel_t             wts [KERNEL * KERNEL];
    logic signed [31:0] out_mem [N_OUT];
    bit                 written [N_OUT];
    logic [31:0]        rng;
    int                 cycles = 0;

    conv_top #(
        .IMG_H (IMG_H),
        .IMG_W (IMG_W)
    ) conv_top_i (
        .clk_i          (clk),
        .reset_i        (reset),
        .valid_i        (valid),
        .ready_o        (ready),
        .input_addr_o   (input_addr),
        .input_rdata_i  (input_rdata),
        .weight_addr_o  (weight_addr),
        .weight_rdata_i (weight_rdata),
        .output_wen_o   (output_wen),
        .output_addr_o  (output_addr),
        .output_wdata_o (output_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Valid cross-correlation, straight from the definition
    function automatic int expected_output(int r, int c);
        int acc;
        acc = 0;
        for (int a = 0; a < KERNEL; a++)
            for (int b = 0; b < KERNEL; b++)
                acc += int'(img[(r + a) * IMG_W + c + b]) * int'(wts[a * KERNEL + b]);
        return acc;
    endfunction

    task automatic stop_run(string reason);
        $display("** FAIL **");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(string name, longint actual, longint expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d",
                     $time, name, actual, expected);
            stop_run("value mismatch");
        end
    endtask

    task automatic step();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    task automatic fill_memories();
        for (int i = 0; i < IMG_H * IMG_W; i++) begin
            rng    = xorshift32(rng);
            img[i] = pixel_t'(int'(rng[4:0]) - 16);  // -16 .. 15
        end
        for (int i = 0; i < KERNEL * KERNEL; i++) begin
            rng    = xorshift32(rng);
            wts[i] = pixel_t'(int'(rng[3:0]) - 8);   // -8 .. 7
        end
        for (int i = 0; i < N_OUT; i++) begin
            out_mem[i] = '0;
            written[i] = 1'b0;
        end
    endtask

    // Four pixels from the flat address on, low byte first
    always_comb begin
        input_rdata  = '0;
        weight_rdata = '0;
        for (int n = 0; n < PIX_PER_WORD; n++) begin
            if (int'(input_addr) + n < IMG_H * IMG_W)
                input_rdata[8*n +: 8] = img[int'(input_addr) + n];
            if (int'(weight_addr) + n < KERNEL * KERNEL)
                weight_rdata[8*n +: 8] = wts[int'(weight_addr) + n];
        end
    end

    always @(posedge clk) begin
        if (output_wen === 1'b1) begin
            if (ready)
                stop_run("output write after ready_o rose");
            else if (int'(output_addr) >= N_OUT)
                stop_run($sformatf("output address %0d out of range", output_addr));
            else begin
                out_mem[output_addr] = output_wdata;
                written[output_addr] = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
            stop_run("timeout, ready_o did not rise within the cycle limit");
    end

    initial begin
        reset = 1'b1;
        valid = 1'b0;
        rng   = SEED;
        for (int run = 0; run < RUNS; run++) begin
            fill_memories();
            @(posedge clk);
            #(DRIVE_DLY);
            reset = 1'b1;
            repeat (5) step();
            reset = 1'b0;
            repeat (4) begin  // Idle until started
                step();
                check_value("ready_o", ready, 0);
                check_value("output_wen_o", output_wen, 0);
            end
            valid = 1'b1;
            step();
            valid = 1'b0;
            while (ready !== 1'b1)
                step();
            for (int i = 0; i < N_OUT; i++) begin
                if (!written[i])
                    stop_run($sformatf("output address %0d was never written", i));
                else
                    check_value($sformatf("output_wdata_o[%0d][%0d]", i / OUT_W, i % OUT_W),
                                out_mem[i], expected_output(i / OUT_W, i % OUT_W));
            end
            repeat (10) begin
                step();
                check_value("output_wen_o", output_wen, 0);
                check_value("ready_o", ready, 1);
            end
            $display("run %0d: %0d outputs compared", run, N_OUT);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/conv_pkg.sv
design/twiddle_rom.sv
design/tile_fft.sv
design/tile_engine.sv
design/tile_scheduler.sv
design/conv_top.sv
dv/conv_chk.sv
dv/tb_conv.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_conv
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
